// File: hdl/soc_mem_pkg.sv
package soc_mem_pkg;

  // ---------------------------------------------------------------------------
  // widths
  // ---------------------------------------------------------------------------
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned DataWidth  = 64;
  localparam int unsigned StrbWidth  = DataWidth / 8;
  // byte offset inside a word that the decoder ignores
  localparam int unsigned WordOffset = 3;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // ---------------------------------------------------------------------------
  // address map
  // ---------------------------------------------------------------------------
  localparam addr_t RomBase    = 32'h0001_0000;
  localparam addr_t RomLength  = 32'h0000_1000;
  localparam addr_t DramBase   = 32'h8000_0000;
  localparam addr_t DramLength = 32'h0000_4000;

  localparam int unsigned RomWords     = RomLength / StrbWidth;
  localparam int unsigned DramWords    = DramLength / StrbWidth;
  localparam int unsigned RomIdxWidth  = $clog2(RomWords);
  localparam int unsigned DramIdxWidth = $clog2(DramWords);

  // host port handshake states
  typedef enum logic [1:0] {
    PS_IDLE,
    PS_ISSUE,
    PS_WAIT,
    PS_ACK
  } port_state_e;

  // decoded destination of one access
  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_DRAM,
    TGT_ERR
  } target_e;

  // boot rom word holds the index low and its inverse high
  function automatic data_t rom_word(input logic [RomIdxWidth-1:0] idx);
    logic [31:0] k;
    k = 32'(idx);
    return {~k, k};
  endfunction

endpackage

// File: hdl/boot_rom.sv
`timescale 1ns/1ps

module boot_rom (
  input  logic                                clk_i,
  input  logic                                req_i,
  input  logic [soc_mem_pkg::RomIdxWidth-1:0] idx_i,
  output soc_mem_pkg::data_t                  rdata_o
);

  import soc_mem_pkg::*;

  data_t rom_data;

  // contents come from the index rule instead of a stored image
  assign rom_data = rom_word(idx_i);

  // one-cycle read with the output held between strobes
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rom_data;
    end
  end

endmodule

// File: hdl/data_sram.sv
`timescale 1ns/1ps

module data_sram (
  input  logic                                 clk_i,
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [soc_mem_pkg::DramIdxWidth-1:0] idx_i,
  input  soc_mem_pkg::data_t                   wdata_i,
  input  soc_mem_pkg::strb_t                   be_i,
  output soc_mem_pkg::data_t                   rdata_o
);

  import soc_mem_pkg::*;

  data_t mem_q [DramWords];

  // ---------------------------------------------------------------------------
  // single port with byte enables
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (be_i[b]) begin
            mem_q[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end
      // read-before-write returns the old word on a write
      rdata_o <= mem_q[idx_i];
    end
  end

endmodule

// File: hdl/host_req_port.sv
`timescale 1ns/1ps

module host_req_port (
  input  logic               clk_i,
  input  logic               rst_ni,
  // four-phase host side
  input  logic               req_i,
  input  logic               we_i,
  input  soc_mem_pkg::addr_t addr_i,
  input  soc_mem_pkg::data_t wdata_i,
  input  soc_mem_pkg::strb_t be_i,
  // response from the router
  input  logic               mem_rvalid_i,
  input  soc_mem_pkg::data_t mem_rdata_i,
  input  logic               mem_err_i,
  output logic               ack_o,
  output soc_mem_pkg::data_t rdata_o,
  output logic               err_o,
  // single-cycle access towards the router
  output logic               mem_req_o,
  output logic               mem_we_o,
  output soc_mem_pkg::addr_t mem_addr_o,
  output soc_mem_pkg::data_t mem_wdata_o,
  output soc_mem_pkg::strb_t mem_be_o
);

  import soc_mem_pkg::*;

  port_state_e state_d, state_q;
  data_t       rdata_q;
  logic        err_q;

  // ---------------------------------------------------------------------------
  // handshake FSM
  // ---------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      PS_IDLE: begin
        if (req_i) begin
          state_d = PS_ISSUE;
        end
      end
      // one strobe per handshake
      PS_ISSUE: state_d = PS_WAIT;
      PS_WAIT: begin
        if (mem_rvalid_i) begin
          state_d = PS_ACK;
        end
      end
      // host drops req to close the transfer
      PS_ACK: begin
        if (!req_i) begin
          state_d = PS_IDLE;
        end
      end
      default: state_d = PS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PS_IDLE;
      rdata_q <= '0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      // response held for the whole ack phase
      if (state_q == PS_WAIT && mem_rvalid_i) begin
        rdata_q <= mem_rdata_i;
        err_q   <= mem_err_i;
      end
    end
  end

  // request fields latched when the handshake is accepted
  always_ff @(posedge clk_i) begin
    if (state_q == PS_IDLE && req_i) begin
      mem_we_o    <= we_i;
      mem_addr_o  <= addr_i;
      mem_wdata_o <= wdata_i;
      mem_be_o    <= be_i;
    end
  end

  assign mem_req_o = (state_q == PS_ISSUE);
  assign ack_o     = (state_q == PS_ACK);
  assign rdata_o   = rdata_q;
  assign err_o     = err_q;

endmodule

// File: hdl/mem_router.sv
`timescale 1ns/1ps

module mem_router (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 mem_req_i,
  input  logic                                 mem_we_i,
  input  soc_mem_pkg::addr_t                   mem_addr_i,
  input  soc_mem_pkg::data_t                   mem_wdata_i,
  input  soc_mem_pkg::strb_t                   mem_be_i,
  input  soc_mem_pkg::data_t                   rom_rdata_i,
  input  soc_mem_pkg::data_t                   sram_rdata_i,
  output logic                                 mem_rvalid_o,
  output soc_mem_pkg::data_t                   mem_rdata_o,
  output logic                                 mem_err_o,
  output logic                                 rom_req_o,
  output logic [soc_mem_pkg::RomIdxWidth-1:0]  rom_idx_o,
  output logic                                 sram_req_o,
  output logic                                 sram_we_o,
  output logic [soc_mem_pkg::DramIdxWidth-1:0] sram_idx_o,
  output soc_mem_pkg::data_t                   sram_wdata_o,
  output soc_mem_pkg::strb_t                   sram_be_o
);

  import soc_mem_pkg::*;

  target_e tgt;
  target_e tgt_q;
  logic    valid_q;
  logic    we_q;
  data_t   rdata_sel;

  // ---------------------------------------------------------------------------
  // address decode
  // ---------------------------------------------------------------------------
  always_comb begin
    if (mem_addr_i >= RomBase && mem_addr_i < RomBase + RomLength) begin
      // rom is read-only
      tgt = mem_we_i ? TGT_ERR : TGT_ROM;
    end else if (mem_addr_i >= DramBase && mem_addr_i < DramBase + DramLength) begin
      tgt = TGT_DRAM;
    end else begin
      tgt = TGT_ERR;
    end
  end

  assign rom_req_o    = mem_req_i && (tgt == TGT_ROM);
  assign rom_idx_o    = mem_addr_i[WordOffset +: RomIdxWidth];
  assign sram_req_o   = mem_req_i && (tgt == TGT_DRAM);
  assign sram_we_o    = mem_we_i;
  assign sram_idx_o   = mem_addr_i[WordOffset +: DramIdxWidth];
  assign sram_wdata_o = mem_wdata_i;
  assign sram_be_o    = mem_be_i;

  // ---------------------------------------------------------------------------
  // response pipeline
  // ---------------------------------------------------------------------------
  // stage 1 runs in parallel with the target read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q      <= 1'b0;
      tgt_q        <= TGT_ERR;
      we_q         <= 1'b0;
      mem_rvalid_o <= 1'b0;
      mem_err_o    <= 1'b0;
    end else begin
      valid_q      <= mem_req_i;
      mem_rvalid_o <= valid_q;
      if (mem_req_i) begin
        tgt_q <= tgt;
        we_q  <= mem_we_i;
      end
      if (valid_q) begin
        mem_err_o <= (tgt_q == TGT_ERR);
      end
    end
  end

  // writes and errors answer with zero data
  always_comb begin
    rdata_sel = '0;
    if (!we_q) begin
      unique case (tgt_q)
        TGT_ROM:  rdata_sel = rom_rdata_i;
        TGT_DRAM: rdata_sel = sram_rdata_i;
        default:  rdata_sel = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_q) begin
      mem_rdata_o <= rdata_sel;
    end
  end

endmodule

// File: hdl/soc_mem_top.sv
`timescale 1ns/1ps

module soc_mem_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  logic               we_i,
  input  soc_mem_pkg::addr_t addr_i,
  input  soc_mem_pkg::data_t wdata_i,
  input  soc_mem_pkg::strb_t be_i,
  output logic               ack_o,
  output soc_mem_pkg::data_t rdata_o,
  output logic               err_o
);

  import soc_mem_pkg::*;

  // port to router
  logic  mem_req;
  logic  mem_we;
  addr_t mem_addr;
  data_t mem_wdata;
  strb_t mem_be;
  logic  mem_rvalid;
  data_t mem_rdata;
  logic  mem_err;

  // router to targets
  logic                    rom_req;
  logic [RomIdxWidth-1:0]  rom_idx;
  data_t                   rom_rdata;
  logic                    sram_req;
  logic                    sram_we;
  logic [DramIdxWidth-1:0] sram_idx;
  data_t                   sram_wdata;
  strb_t                   sram_be;
  data_t                   sram_rdata;

  host_req_port i_host_req_port (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .req_i        ( req_i      ),
    .we_i         ( we_i       ),
    .addr_i       ( addr_i     ),
    .wdata_i      ( wdata_i    ),
    .be_i         ( be_i       ),
    .mem_rvalid_i ( mem_rvalid ),
    .mem_rdata_i  ( mem_rdata  ),
    .mem_err_i    ( mem_err    ),
    .ack_o        ( ack_o      ),
    .rdata_o      ( rdata_o    ),
    .err_o        ( err_o      ),
    .mem_req_o    ( mem_req    ),
    .mem_we_o     ( mem_we     ),
    .mem_addr_o   ( mem_addr   ),
    .mem_wdata_o  ( mem_wdata  ),
    .mem_be_o     ( mem_be     )
  );

  mem_router i_mem_router (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .mem_req_i    ( mem_req    ),
    .mem_we_i     ( mem_we     ),
    .mem_addr_i   ( mem_addr   ),
    .mem_wdata_i  ( mem_wdata  ),
    .mem_be_i     ( mem_be     ),
    .rom_rdata_i  ( rom_rdata  ),
    .sram_rdata_i ( sram_rdata ),
    .mem_rvalid_o ( mem_rvalid ),
    .mem_rdata_o  ( mem_rdata  ),
    .mem_err_o    ( mem_err    ),
    .rom_req_o    ( rom_req    ),
    .rom_idx_o    ( rom_idx    ),
    .sram_req_o   ( sram_req   ),
    .sram_we_o    ( sram_we    ),
    .sram_idx_o   ( sram_idx   ),
    .sram_wdata_o ( sram_wdata ),
    .sram_be_o    ( sram_be    )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .idx_i   ( rom_idx   ),
    .rdata_o ( rom_rdata )
  );

  data_sram i_data_sram (
    .clk_i   ( clk_i      ),
    .req_i   ( sram_req   ),
    .we_i    ( sram_we    ),
    .idx_i   ( sram_idx   ),
    .wdata_i ( sram_wdata ),
    .be_i    ( sram_be    ),
    .rdata_o ( sram_rdata )
  );

endmodule

// File: verif/soc_mem_asserts.sv
`timescale 1ns/1ps

module soc_mem_asserts (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               req_i,
  input logic               ack_i,
  input soc_mem_pkg::data_t rdata_i,
  input logic               err_i
);

  int fail_cnt;

  initial fail_cnt = 0;

  // ack only answers a pending request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ack_i) |-> $past(req_i))
  else begin
    $error("ack_o rose while req_i was low");
    fail_cnt++;
  end

  resp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_i && $past(ack_i)) |-> ($stable(rdata_i) && $stable(err_i)))
  else begin
    $error("response changed while ack_o was high");
    fail_cnt++;
  end

  ack_falls_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(ack_i) |-> !$past(req_i))
  else begin
    $error("ack_o fell while req_i was still high");
    fail_cnt++;
  end

endmodule

bind soc_mem_top soc_mem_asserts i_asserts (
  .clk_i   ( clk_i   ),
  .rst_ni  ( rst_ni  ),
  .req_i   ( req_i   ),
  .ack_i   ( ack_o   ),
  .rdata_i ( rdata_o ),
  .err_i   ( err_o   )
);

// File: verif/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  logic               we_i,
  input  soc_mem_pkg::addr_t addr_i,
  input  soc_mem_pkg::data_t wdata_i,
  input  soc_mem_pkg::strb_t be_i,
  input  logic               ack_i,
  input  soc_mem_pkg::data_t rdata_i,
  input  logic               err_i,
  output int                 mismatch_cnt_o,
  output int                 model_err_cnt_o,
  output int                 resp_cnt_o
);

  import soc_mem_pkg::*;

  logic  req_q;
  logic  ack_q;
  // request captured when req rises
  logic  cur_we;
  addr_t cur_addr;
  data_t cur_wdata;
  strb_t cur_be;

  // sparse dram image keyed by word index
  data_t dram_img [int unsigned];

  // word k holds k low and ~k high
  function automatic data_t rom_expect(input addr_t addr);
    logic [31:0] k;
    k = (addr - RomBase) >> WordOffset;
    return {~k, k};
  endfunction

  function automatic logic in_rom(input addr_t addr);
    return (addr >= RomBase) && (addr < RomBase + RomLength);
  endfunction

  function automatic logic in_dram(input addr_t addr);
    return (addr >= DramBase) && (addr < DramBase + DramLength);
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input strb_t be);
    data_t res;
    res = old;
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_response();
    data_t       exp_data;
    logic        exp_err;
    int unsigned widx;
    exp_data = '0;
    exp_err  = 1'b0;
    widx     = (cur_addr - DramBase) >> WordOffset;
    if (in_rom(cur_addr)) begin
      if (cur_we) begin
        exp_err = 1'b1;
      end else begin
        exp_data = rom_expect(cur_addr);
      end
    end else if (in_dram(cur_addr)) begin
      if (cur_we && dram_img.exists(widx)) begin
        dram_img[widx] = merge_bytes(dram_img[widx], cur_wdata, cur_be);
      end else if (cur_we && cur_be == '1) begin
        dram_img[widx] = cur_wdata;
      end else if (cur_we) begin
        $display("partial write at %0t to DRAM word %0d with unknown contents", $time, widx);
        model_err_cnt_o++;
      end else if (dram_img.exists(widx)) begin
        exp_data = dram_img[widx];
      end else begin
        $display("read at %0t of DRAM word %0d that was never written", $time, widx);
        model_err_cnt_o++;
      end
    end else begin
      exp_err = 1'b1;
    end
    if (rdata_i !== exp_data || err_i !== exp_err) begin
      $display("Fail %0t: %s addr %h gave rdata %h err %b, expected %h err %b", $time,
               cur_we ? "write" : "read", cur_addr, rdata_i, err_i, exp_data, exp_err);
      mismatch_cnt_o++;
    end
  endtask

  // sampled mid-cycle away from the driving edge
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      req_q           <= 1'b0;
      ack_q           <= 1'b0;
      mismatch_cnt_o  = 0;
      model_err_cnt_o = 0;
      resp_cnt_o      = 0;
    end else begin
      req_q <= req_i;
      ack_q <= ack_i;
      if (req_i && !req_q) begin
        cur_we    = we_i;
        cur_addr  = addr_i;
        cur_wdata = wdata_i;
        cur_be    = be_i;
      end
      if (ack_i && !ack_q) begin
        resp_cnt_o++;
        check_response();
      end
    end
  end

endmodule

// File: verif/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  import soc_mem_pkg::*;

  localparam int ClkPeriod   = 8;
  localparam int ResetCycles = 5;
  localparam int PoolWords   = 16;
  // rom reads, full write/read pairs, partial pairs, error cases, random mix
  localparam int NumTrans    = 20 + 32 + 16 + 12 + 300;

  logic  clk_i;
  logic  rst_ni;
  logic  req_i;
  logic  we_i;
  addr_t addr_i;
  data_t wdata_i;
  strb_t be_i;
  logic  ack_o;
  data_t rdata_o;
  logic  err_o;

  integer seed;
  int     issued;
  int     mismatch_cnt;
  int     model_err_cnt;
  int     resp_cnt;
  int     total_err;
  // dram words that hold known contents
  addr_t  pool [PoolWords];
  addr_t  err_addr [4];

  soc_mem_top uut (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .req_i   ( req_i   ),
    .we_i    ( we_i    ),
    .addr_i  ( addr_i  ),
    .wdata_i ( wdata_i ),
    .be_i    ( be_i    ),
    .ack_o   ( ack_o   ),
    .rdata_o ( rdata_o ),
    .err_o   ( err_o   )
  );

  tb_checker i_checker (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .req_i           ( req_i         ),
    .we_i            ( we_i          ),
    .addr_i          ( addr_i        ),
    .wdata_i         ( wdata_i       ),
    .be_i            ( be_i          ),
    .ack_i           ( ack_o         ),
    .rdata_i         ( rdata_o       ),
    .err_i           ( err_o         ),
    .mismatch_cnt_o  ( mismatch_cnt  ),
    .model_err_cnt_o ( model_err_cnt ),
    .resp_cnt_o      ( resp_cnt      )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // watchdog allows 20 cycles per handshake
  initial begin
    #((NumTrans * 20 + ResetCycles) * ClkPeriod);
    $display("timeout: handshakes did not finish within %0d cycles",
             NumTrans * 20 + ResetCycles);
    $display("tests failed");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  // ---------------------------------------------------------------------------
  // four-phase host
  // ---------------------------------------------------------------------------
  // entered and left 1 ns after a rising edge
  task automatic access(input logic we, input addr_t addr, input data_t wdata,
                        input strb_t be, input logic [1:0] hold);
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    be_i    = be;
    req_i   = 1'b1;
    do begin
      @(posedge clk_i);
      #1;
    end while (!ack_o);
    // back-pressure before closing the transfer
    repeat (hold) begin
      @(posedge clk_i);
      #1;
    end
    req_i = 1'b0;
    do begin
      @(posedge clk_i);
      #1;
    end while (ack_o);
    issued++;
  endtask

  task automatic read_at(input addr_t addr);
    access(1'b0, addr, '0, '0, 2'd0);
  endtask

  task automatic write_at(input addr_t addr, input data_t wdata, input strb_t be);
    access(1'b1, addr, wdata, be, 2'd0);
  endtask

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------
  initial begin
    logic [31:0] r;
    logic [31:0] s;
    addr_t       a;
    seed    = 54;
    issued  = 0;
    rst_ni  = 1'b0;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    for (int i = 0; i < 20; i++) begin
      read_at(RomBase + (next_rand() & 32'h0000_0fff));
    end

    // full writes fill the pool and each is read back at once
    for (int i = 0; i < PoolWords; i++) begin
      pool[i] = DramBase + (next_rand() & 32'h0000_3ff8);
      write_at(pool[i], {next_rand(), next_rand()}, 8'hff);
      read_at(pool[i]);
    end

    for (int i = 0; i < 8; i++) begin
      r = next_rand();
      a = pool[r[3:0]];
      write_at(a, {next_rand(), next_rand()}, r[11:4]);
      read_at(a);
    end

    // rom writes and unmapped addresses
    for (int i = 0; i < 4; i++) begin
      err_addr[i] = RomBase + (next_rand() & 32'h0000_0ff8);
      write_at(err_addr[i], {next_rand(), next_rand()}, 8'hff);
    end
    read_at(32'h0000_0100);
    write_at(RomBase + RomLength, {next_rand(), next_rand()}, 8'hff);
    read_at(DramBase + DramLength);
    write_at(32'hffff_fff8, {next_rand(), next_rand()}, 8'h0f);
    for (int i = 0; i < 4; i++) begin
      read_at(err_addr[i]);
    end

    // random mix with random hold times
    for (int i = 0; i < 300; i++) begin
      r = next_rand();
      s = next_rand();
      if (r[3:0] < 4'd6) begin
        access(1'b0, RomBase + (s & 32'h0000_0fff), '0, '0, r[5:4]);
      end else if (r[3:0] < 4'd8) begin
        a = s[0] ? RomBase + (s & 32'h0000_0ff8) : 32'h4000_0000 + (s & 32'h0fff_fff8);
        access(s[0] | r[6], a, {next_rand(), next_rand()}, r[15:8], r[5:4]);
      end else begin
        a = pool[s[3:0]] | {29'b0, s[6:4]};
        access(r[6], a, {next_rand(), next_rand()}, r[15:8], r[5:4]);
      end
    end

    repeat (4) @(posedge clk_i);
    total_err = mismatch_cnt + model_err_cnt + uut.i_asserts.fail_cnt;
    if (resp_cnt != issued) begin
      $display("%0d responses seen for %0d handshakes", resp_cnt, issued);
      total_err++;
    end
    $display("errors: %0d mismatches, %0d model errors, %0d assertion failures",
             mismatch_cnt, model_err_cnt, uut.i_asserts.fail_cnt);
    if (total_err == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
hdl/soc_mem_pkg.sv
hdl/boot_rom.sv
hdl/data_sram.sv
hdl/host_req_port.sv
hdl/mem_router.sv
hdl/soc_mem_top.sv
verif/soc_mem_asserts.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_top -f filelist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_top +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
